// ==== rtl/ckpt_pkg.sv ====
package ckpt_pkg;

    // core sizing
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 32;
    localparam int BR_DEPTH  = 4;
    localparam int ROB_SIZE  = 16;
    localparam int CDB_LANES = 2;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [BR_DEPTH-1:0]          br_mask_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] fl_ptr_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]  rob_ptr_t;
    typedef logic [31:0]                  addr_t;

    typedef struct packed {
        phys_reg_t tag;
        logic      ready;
    } map_entry_t;

    // index with the architectural register number
    typedef map_entry_t [ARCH_REGS-1:0] map_array_t;

    typedef struct packed {
        logic      valid;
        logic      is_branch;
        logic      has_dest;
        arch_reg_t arch_dest;
        phys_reg_t phys_dest;
        addr_t     pc;
    } dispatch_pkt_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t arch_reg;
        phys_reg_t phys_reg;
    } cdb_pkt_t;

    typedef struct packed {
        logic     valid;
        logic     mispredict;
        br_mask_t b_id;
    } resolve_pkt_t;

    typedef struct packed {
        logic       valid;
        br_mask_t   b_id;
        br_mask_t   b_mask;
        addr_t      rec_pc;
        map_array_t rec_map;
        fl_ptr_t    fl_head;
        rob_ptr_t   rob_tail;
    } checkpoint_t;

    typedef enum logic {
        IDLE,
        RESTORE
    } recov_state_t;

    // sets ready on every entry whose tag matches a broadcast on its register
    function automatic map_array_t wake_map(input map_array_t map_in,
                                            input cdb_pkt_t [CDB_LANES-1:0] lanes);
        map_array_t map_out;
        map_out = map_in;
        for (int l = 0; l < CDB_LANES; l++) begin
            if (lanes[l].valid && map_out[lanes[l].arch_reg].tag == lanes[l].phys_reg) begin
                map_out[lanes[l].arch_reg].ready = 1'b1;
            end
        end
        return map_out;
    endfunction

endpackage

// ==== rtl/map_table.sv ====
module map_table (
    input  logic                                          clock,
    input  logic                                          reset,

    input  ckpt_pkg::arch_reg_t                           lookup_reg,

    input  logic                                          rename_we,
    input  ckpt_pkg::arch_reg_t                           rename_reg,
    input  ckpt_pkg::phys_reg_t                           rename_tag,

    input  ckpt_pkg::cdb_pkt_t [ckpt_pkg::CDB_LANES-1:0]  cdb,

    input  logic                                          restore,
    input  ckpt_pkg::map_array_t                          restore_map,

    output ckpt_pkg::map_entry_t                          lookup_entry,
    output ckpt_pkg::map_array_t                          map_now
);

    ckpt_pkg::map_array_t map_q;
    ckpt_pkg::map_array_t map_next;

    always_comb begin
        if (restore) begin
            // branch stack has already merged this cycle's broadcasts
            map_next = restore_map;
        end else begin
            map_next = ckpt_pkg::wake_map(map_q, cdb);
            // a new rename overrides any wakeup aimed at the old tag
            if (rename_we) begin
                map_next[rename_reg].tag   = rename_tag;
                map_next[rename_reg].ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, everything ready
            for (int i = 0; i < ckpt_pkg::ARCH_REGS; i++) begin
                map_q[i].tag   <= ckpt_pkg::phys_reg_t'(i);
                map_q[i].ready <= 1'b1;
            end
        end else begin
            map_q <= map_next;
        end
    end

    assign lookup_entry = map_q[lookup_reg];
    assign map_now      = map_q;

    // dispatch must be held off for the whole restore cycle
    assert property (@(posedge clock) disable iff (reset)
        !(rename_we && restore))
        else $error("map_table: rename during restore");

endmodule

// ==== rtl/branch_stack.sv ====
module branch_stack (
    input  logic                                          clock,
    input  logic                                          reset,

    input  logic                                          alloc,
    input  ckpt_pkg::addr_t                               alloc_pc,
    input  ckpt_pkg::map_array_t                          alloc_map,
    input  ckpt_pkg::fl_ptr_t                             alloc_fl_head,
    input  ckpt_pkg::rob_ptr_t                            alloc_rob_tail,

    input  ckpt_pkg::cdb_pkt_t [ckpt_pkg::CDB_LANES-1:0]  cdb,
    input  ckpt_pkg::resolve_pkt_t                        resolve,

    output ckpt_pkg::br_mask_t                            free_bid,
    output ckpt_pkg::br_mask_t                            live_mask,
    output logic                                          full,
    output ckpt_pkg::checkpoint_t                         recover_ckpt
);

    ckpt_pkg::checkpoint_t [ckpt_pkg::BR_DEPTH-1:0] entries;
    ckpt_pkg::checkpoint_t [ckpt_pkg::BR_DEPTH-1:0] next_entries;
    ckpt_pkg::checkpoint_t                          recov_q;
    ckpt_pkg::checkpoint_t                          next_recov;
    ckpt_pkg::br_mask_t                             alloc_mask;

    // entry i always owns one-hot id bit i
    always_comb begin
        for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
            live_mask[i] = entries[i].valid;
        end
    end

    // lowest free slot wins, so scan from the top down
    always_comb begin
        free_bid = '0;
        for (int i = ckpt_pkg::BR_DEPTH - 1; i >= 0; i--) begin
            if (!live_mask[i]) begin
                free_bid = ckpt_pkg::br_mask_t'(1) << i;
            end
        end
    end

    assign full = &live_mask;

    // held checkpoint keeps catching broadcasts until the restore lands
    always_comb begin
        recover_ckpt         = recov_q;
        recover_ckpt.rec_map = ckpt_pkg::wake_map(recov_q.rec_map, cdb);
    end

    always_comb begin
        next_entries = entries;
        next_recov   = recover_ckpt;

        if (resolve.valid) begin
            for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
                if (entries[i].valid) begin
                    if (entries[i].b_id == resolve.b_id) begin
                        next_entries[i].valid = 1'b0;
                        if (resolve.mispredict) begin
                            next_recov = entries[i];
                        end
                    end else if ((entries[i].b_mask & resolve.b_id) != '0) begin
                        // younger than the resolved branch
                        if (resolve.mispredict) begin
                            next_entries[i].valid = 1'b0;
                        end else begin
                            next_entries[i].b_mask = entries[i].b_mask & ~resolve.b_id;
                        end
                    end
                end
            end
        end

        // older live branches, minus anything cleared this cycle
        for (int j = 0; j < ckpt_pkg::BR_DEPTH; j++) begin
            alloc_mask[j] = next_entries[j].valid;
        end

        if (alloc) begin
            for (int k = 0; k < ckpt_pkg::BR_DEPTH; k++) begin
                if (free_bid[k]) begin
                    next_entries[k].valid    = 1'b1;
                    next_entries[k].b_id     = free_bid;
                    next_entries[k].b_mask   = alloc_mask;
                    next_entries[k].rec_pc   = alloc_pc;
                    next_entries[k].rec_map  = alloc_map;
                    next_entries[k].fl_head  = alloc_fl_head;
                    next_entries[k].rob_tail = alloc_rob_tail;
                end
            end
        end

        for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
            next_entries[i].rec_map = ckpt_pkg::wake_map(next_entries[i].rec_map, cdb);
        end
        next_recov.rec_map = ckpt_pkg::wake_map(next_recov.rec_map, cdb);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
            recov_q <= '0;
        end else begin
            entries <= next_entries;
            recov_q <= next_recov;
        end
    end

    // recovery_ctrl must hold branches back when the stack is full
    assert property (@(posedge clock) disable iff (reset)
        alloc |-> !full)
        else $error("branch_stack: allocation while full");

    assert property (@(posedge clock) disable iff (reset)
        resolve.valid |-> $onehot(resolve.b_id) && ((resolve.b_id & live_mask) != '0))
        else $error("branch_stack: resolve does not name one live branch");

endmodule

// ==== rtl/ring_pointers.sv ====
module ring_pointers (
    input  logic                clock,
    input  logic                reset,

    input  logic                advance,
    input  logic                has_dest,

    input  logic                restore,
    input  ckpt_pkg::fl_ptr_t   restore_fl_head,
    input  ckpt_pkg::rob_ptr_t  restore_rob_tail,

    output ckpt_pkg::fl_ptr_t   fl_head,
    output ckpt_pkg::rob_ptr_t  rob_tail
);

    // both counters wrap naturally at their type width
    always_ff @(posedge clock) begin
        if (reset) begin
            fl_head  <= '0;
            rob_tail <= '0;
        end else if (restore) begin
            fl_head  <= restore_fl_head;
            rob_tail <= restore_rob_tail;
        end else if (advance) begin
            rob_tail <= ckpt_pkg::rob_ptr_t'(rob_tail + 1'b1);
            // only instructions that write a register take a free tag
            if (has_dest) begin
                fl_head <= ckpt_pkg::fl_ptr_t'(fl_head + 1'b1);
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        !(advance && restore))
        else $error("ring_pointers: advance during restore");

endmodule

// ==== rtl/recovery_ctrl.sv ====
module recovery_ctrl (
    input  logic                    clock,
    input  logic                    reset,

    input  ckpt_pkg::dispatch_pkt_t dispatch,
    input  ckpt_pkg::resolve_pkt_t  resolve,
    input  logic                    stack_full,
    input  ckpt_pkg::addr_t         ckpt_pc,

    output logic                    dispatch_ready,
    output logic                    dispatch_fire,
    output logic                    restore,
    output logic                    recover_valid,
    output ckpt_pkg::addr_t         recover_pc
);

    ckpt_pkg::recov_state_t state_q;
    ckpt_pkg::recov_state_t state_next;
    logic                   mispredict;

    assign mispredict = resolve.valid && resolve.mispredict;

    always_comb begin
        state_next = state_q;
        case (state_q)
            ckpt_pkg::IDLE: begin
                if (mispredict) begin
                    state_next = ckpt_pkg::RESTORE;
                end
            end
            // restore always completes in a single cycle
            ckpt_pkg::RESTORE: state_next = ckpt_pkg::IDLE;
            default: state_next = ckpt_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= ckpt_pkg::IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // branches also need a free checkpoint slot
    assign dispatch_ready = (state_q == ckpt_pkg::IDLE) && !mispredict &&
                            (!dispatch.is_branch || !stack_full);
    assign dispatch_fire  = dispatch.valid && dispatch_ready;

    assign restore        = (state_q == ckpt_pkg::RESTORE);
    assign recover_valid  = restore;
    assign recover_pc     = ckpt_pc;

    // the squashed branches cannot resolve, and nothing younger was dispatched
    assert property (@(posedge clock) disable iff (reset)
        (state_q == ckpt_pkg::RESTORE) |-> !resolve.valid)
        else $error("recovery_ctrl: resolve during restore");

endmodule

// ==== rtl/rename_ckpt_top.sv ====
module rename_ckpt_top (
    input  logic                                          clock,
    input  logic                                          reset,

    input  ckpt_pkg::dispatch_pkt_t                       dispatch,
    input  ckpt_pkg::cdb_pkt_t [ckpt_pkg::CDB_LANES-1:0]  cdb,
    input  ckpt_pkg::resolve_pkt_t                        resolve,
    input  ckpt_pkg::arch_reg_t                           lookup_reg,

    output logic                                          dispatch_ready,
    output ckpt_pkg::br_mask_t                            dispatch_bid,
    output ckpt_pkg::br_mask_t                            dispatch_mask,
    output ckpt_pkg::map_entry_t                          lookup_entry,
    output ckpt_pkg::fl_ptr_t                             fl_head,
    output ckpt_pkg::rob_ptr_t                            rob_tail,
    output logic                                          recover_valid,
    output ckpt_pkg::addr_t                               recover_pc
);

    logic                  dispatch_fire;
    logic                  restore;
    logic                  stack_full;
    logic                  rename_we;
    logic                  alloc;
    ckpt_pkg::map_array_t  map_now;
    ckpt_pkg::checkpoint_t recover_ckpt;

    assign rename_we = dispatch_fire && dispatch.has_dest;
    assign alloc     = dispatch_fire && dispatch.is_branch;

    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .lookup_reg   (lookup_reg),
        .rename_we    (rename_we),
        .rename_reg   (dispatch.arch_dest),
        .rename_tag   (dispatch.phys_dest),
        .cdb          (cdb),
        .restore      (restore),
        .restore_map  (recover_ckpt.rec_map),
        .lookup_entry (lookup_entry),
        .map_now      (map_now)
    );

    // checkpoint captures map and pointers before this instruction renames
    branch_stack u_branch_stack (
        .clock          (clock),
        .reset          (reset),
        .alloc          (alloc),
        .alloc_pc       (dispatch.pc),
        .alloc_map      (map_now),
        .alloc_fl_head  (fl_head),
        .alloc_rob_tail (rob_tail),
        .cdb            (cdb),
        .resolve        (resolve),
        .free_bid       (dispatch_bid),
        .live_mask      (dispatch_mask),
        .full           (stack_full),
        .recover_ckpt   (recover_ckpt)
    );

    ring_pointers u_ring_pointers (
        .clock            (clock),
        .reset            (reset),
        .advance          (dispatch_fire),
        .has_dest         (dispatch.has_dest),
        .restore          (restore),
        .restore_fl_head  (recover_ckpt.fl_head),
        .restore_rob_tail (recover_ckpt.rob_tail),
        .fl_head          (fl_head),
        .rob_tail         (rob_tail)
    );

    recovery_ctrl u_recovery_ctrl (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .resolve        (resolve),
        .stack_full     (stack_full),
        .ckpt_pc        (recover_ckpt.rec_pc),
        .dispatch_ready (dispatch_ready),
        .dispatch_fire  (dispatch_fire),
        .restore        (restore),
        .recover_valid  (recover_valid),
        .recover_pc     (recover_pc)
    );

endmodule

// ==== tests/rename_ckpt_tb.sv ====
module rename_ckpt_tb;

    localparam int WAIT_LIMIT = 20;

    logic                                          clock;
    logic                                          reset;
    ckpt_pkg::dispatch_pkt_t                       dispatch;
    ckpt_pkg::cdb_pkt_t [ckpt_pkg::CDB_LANES-1:0]  cdb;
    ckpt_pkg::resolve_pkt_t                        resolve;
    ckpt_pkg::arch_reg_t                           lookup_reg;

    logic                                          dispatch_ready;
    ckpt_pkg::br_mask_t                            dispatch_bid;
    ckpt_pkg::br_mask_t                            dispatch_mask;
    ckpt_pkg::map_entry_t                          lookup_entry;
    ckpt_pkg::fl_ptr_t                             fl_head;
    ckpt_pkg::rob_ptr_t                            rob_tail;
    logic                                          recover_valid;
    ckpt_pkg::addr_t                               recover_pc;

    int errors;
    int checks;
    int tests;
    bit timed_out;

    // expected live branches and the older-branch mask of each id
    ckpt_pkg::br_mask_t                            model_live;
    ckpt_pkg::br_mask_t                            model_mask [ckpt_pkg::BR_DEPTH];

    rename_ckpt_top UUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .resolve        (resolve),
        .lookup_reg     (lookup_reg),
        .dispatch_ready (dispatch_ready),
        .dispatch_bid   (dispatch_bid),
        .dispatch_mask  (dispatch_mask),
        .lookup_entry   (lookup_entry),
        .fl_head        (fl_head),
        .rob_tail       (rob_tail),
        .recover_valid  (recover_valid),
        .recover_pc     (recover_pc)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // a new branch depends on every branch that is live when it arrives
    task automatic record_allocation(input ckpt_pkg::br_mask_t bid);
        for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
            if (bid[i]) begin
                model_mask[i] = model_live;
            end
        end
        model_live = model_live | bid;
    endtask

    // a mispredict also drops every branch that depends on the resolved one
    task automatic release_branches(input logic mispredict, input ckpt_pkg::br_mask_t bid);
        ckpt_pkg::br_mask_t dropped;
        dropped = bid;
        for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
            if (model_live[i] && (model_mask[i] & bid) != '0) begin
                if (mispredict) begin
                    dropped[i] = 1'b1;
                end else begin
                    model_mask[i] = model_mask[i] & ~bid;
                end
            end
        end
        model_live = model_live & ~dropped;
    endtask

    task automatic issue_dispatch(input logic [31:0] is_br, input logic [31:0] has_dest,
                                  input logic [31:0] areg, input logic [31:0] ptag,
                                  input logic [31:0] pc, input logic [31:0] exp_ready,
                                  input logic [31:0] exp_bid, input int line_no);
        ckpt_pkg::dispatch_pkt_t pkt;
        int                      waited;
        pkt           = '0;
        pkt.valid     = 1'b1;
        pkt.is_branch = is_br[0];
        pkt.has_dest  = has_dest[0];
        pkt.arch_dest = ckpt_pkg::arch_reg_t'(areg);
        pkt.phys_dest = ckpt_pkg::phys_reg_t'(ptag);
        pkt.pc        = pc;
        @(posedge clock);
        dispatch <= pkt;
        @(negedge clock);
        if (exp_ready[0] == 1'b0) begin
            // probe only, the instruction is withdrawn again
            compare_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
        end else begin
            waited = 0;
            while (!dispatch_ready && waited < WAIT_LIMIT) begin
                @(negedge clock);
                waited++;
            end
            if (!dispatch_ready) begin
                $display("timeout: the dispatch on line %0d was never accepted", line_no);
                errors++;
                timed_out = 1'b1;
            end else if (pkt.is_branch) begin
                compare_value("dispatch_bid", 32'(dispatch_bid), exp_bid);
                compare_value("dispatch_mask", 32'(dispatch_mask), 32'(model_live));
                record_allocation(ckpt_pkg::br_mask_t'(exp_bid));
            end
        end
        @(posedge clock);
        dispatch <= '0;
    endtask

    task automatic broadcast_cdb(input logic [31:0] v0, input logic [31:0] r0,
                                 input logic [31:0] t0, input logic [31:0] v1,
                                 input logic [31:0] r1, input logic [31:0] t1);
        ckpt_pkg::cdb_pkt_t [ckpt_pkg::CDB_LANES-1:0] lanes;
        lanes = '0;
        lanes[0].valid    = v0[0];
        lanes[0].arch_reg = ckpt_pkg::arch_reg_t'(r0);
        lanes[0].phys_reg = ckpt_pkg::phys_reg_t'(t0);
        lanes[1].valid    = v1[0];
        lanes[1].arch_reg = ckpt_pkg::arch_reg_t'(r1);
        lanes[1].phys_reg = ckpt_pkg::phys_reg_t'(t1);
        @(posedge clock);
        cdb <= lanes;
        @(posedge clock);
        cdb <= '0;
    endtask

    task automatic apply_resolve(input logic [31:0] mispredict, input logic [31:0] bid,
                                 input logic [31:0] pc, input int line_no);
        ckpt_pkg::resolve_pkt_t pkt;
        int                     waited;
        pkt.valid      = 1'b1;
        pkt.mispredict = mispredict[0];
        pkt.b_id       = ckpt_pkg::br_mask_t'(bid);
        @(posedge clock);
        resolve <= pkt;
        // the resolve edge
        @(posedge clock);
        resolve <= '0;
        release_branches(pkt.mispredict, pkt.b_id);
        @(negedge clock);
        if (pkt.mispredict) begin
            waited = 0;
            while (!recover_valid && waited < WAIT_LIMIT) begin
                @(negedge clock);
                waited++;
            end
            if (!recover_valid) begin
                $display("timeout: no recovery after the mispredict on line %0d", line_no);
                errors++;
                timed_out = 1'b1;
            end else begin
                // redirect belongs in the first cycle after the resolve edge
                compare_value("recover_latency", waited, 32'd0);
                compare_value("recover_pc", recover_pc, pc);
                @(negedge clock);
                compare_value("recover_valid", 32'(recover_valid), 32'd0);
            end
        end else begin
            compare_value("recover_valid", 32'(recover_valid), 32'd0);
        end
    endtask

    task automatic check_state(input logic [31:0] areg, input logic [31:0] tag,
                               input logic [31:0] ready, input logic [31:0] fl,
                               input logic [31:0] rob, input logic [31:0] bid);
        @(posedge clock);
        lookup_reg <= ckpt_pkg::arch_reg_t'(areg);
        @(negedge clock);
        compare_value("lookup_entry.tag", 32'(lookup_entry.tag), tag);
        compare_value("lookup_entry.ready", 32'(lookup_entry.ready), ready);
        compare_value("fl_head", 32'(fl_head), fl);
        compare_value("rob_tail", 32'(rob_tail), rob);
        compare_value("dispatch_bid", 32'(dispatch_bid), bid);
        compare_value("dispatch_mask", 32'(dispatch_mask), 32'(model_live));
    endtask

    initial begin
        int               fd;
        int               n;
        int               line_no;
        int               errors_before;
        logic [8*160-1:0] line_buf;
        logic [63:0]      cmd_word;
        logic [31:0]      f0, f1, f2, f3, f4, f5, f6;
        string            kind;

        errors     = 0;
        checks     = 0;
        tests      = 0;
        timed_out  = 1'b0;
        line_no    = 0;
        model_live = '0;
        for (int i = 0; i < ckpt_pkg::BR_DEPTH; i++) begin
            model_mask[i] = '0;
        end
        reset      = 1'b1;
        dispatch   = '0;
        cdb        = '0;
        resolve    = '0;
        lookup_reg = '0;

        fd = $fopen("tests/rename_ckpt_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/rename_ckpt_input.txt");
            errors++;
        end else begin
            repeat (4) @(posedge clock);
            reset <= 1'b0;
            while (!timed_out && $feof(fd) == 0) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                line_no++;
                if (n > 0) begin
                    cmd_word = '0;
                    {f0, f1, f2, f3, f4, f5, f6} = '0;
                    n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h",
                                cmd_word, f0, f1, f2, f3, f4, f5, f6);
                    if (n >= 1 && cmd_word != 64'("#")) begin
                        errors_before = errors;
                        tests++;
                        if (cmd_word == 64'("dispatch")) begin
                            kind = "dispatch";
                            issue_dispatch(f0, f1, f2, f3, f4, f5, f6, line_no);
                        end else if (cmd_word == 64'("cdb")) begin
                            kind = "cdb";
                            broadcast_cdb(f0, f1, f2, f3, f4, f5);
                        end else if (cmd_word == 64'("resolve")) begin
                            kind = "resolve";
                            apply_resolve(f0, f1, f2, line_no);
                        end else if (cmd_word == 64'("idle")) begin
                            kind = "idle";
                            repeat (f0) @(posedge clock);
                        end else if (cmd_word == 64'("check")) begin
                            kind = "check";
                            check_state(f0, f1, f2, f3, f4, f5);
                        end else begin
                            kind = "unknown";
                            $display("line %0d holds an unknown command", line_no);
                            errors++;
                        end
                        if (errors == errors_before) begin
                            $display("line %0d %s: ok", line_no, kind);
                        end else begin
                            $display("line %0d %s: %0d problem(s)", line_no, kind,
                                     errors - errors_before);
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tests/rename_ckpt_input.txt ====
# columns: command f0 f1 f2 f3 f4 f5 f6, every field in hex
# dispatch: branch dest areg ptag pc ready bid | cdb: v0 reg0 tag0 v1 reg1 tag1
# resolve: mispredict bid pc | idle: cycles | check: reg tag ready fl_head rob_tail free_bid
check 0 00 1 00 0 1 0
dispatch 0 1 1 08 00001000 1 0
check 1 08 0 01 1 1 0
dispatch 0 0 0 00 00001004 1 0
dispatch 0 1 2 09 00001008 1 0
check 2 09 0 02 3 1 0
cdb 1 1 08 1 2 0a 0
check 1 08 1 02 3 1 0
check 2 09 0 02 3 1 0
dispatch 1 0 0 00 00002000 1 1
dispatch 0 1 3 0a 00002004 1 0
dispatch 1 0 0 00 00002008 1 2
dispatch 1 0 0 00 0000200c 1 4
dispatch 1 0 0 00 00002010 1 8
check 0 00 1 03 8 0 0
dispatch 1 0 0 00 00002014 0 0
dispatch 0 1 4 0b 00002018 1 0
check 4 0b 0 04 9 0 0
resolve 0 4 00000000 0 0 0 0
check 4 0b 0 04 9 4 0
dispatch 1 0 0 00 0000201c 1 4
dispatch 0 1 5 0c 00002020 1 0
cdb 1 2 09 0 0 00 0
check 2 09 1 05 b 0 0
resolve 1 2 00002008 0 0 0 0
check 2 09 1 03 5 2 0
check 3 0a 0 03 5 2 0
check 4 04 1 03 5 2 0
check 5 05 1 03 5 2 0
resolve 1 1 00002000 0 0 0 0
idle 2 0 0 0 0 0 0
check 3 03 1 02 3 1 0
check 1 08 1 02 3 1 0
dispatch 1 0 0 00 00003000 1 1
check 0 00 1 02 4 2 0

// ==== build.f ====
rtl/ckpt_pkg.sv
rtl/map_table.sv
rtl/branch_stack.sv
rtl/ring_pointers.sv
rtl/recovery_ctrl.sv
rtl/rename_ckpt_top.sv
tests/rename_ckpt_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, then look for the fail message in the log
set -u

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --assert --top-module rename_ckpt_tb -f build.f -Mdir obj_dir -o rename_ckpt_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rename_ckpt_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
